// ==== verilog.f ====
hdl/lsu_cfg_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/store_queue.sv
hdl/store_forward.sv
hdl/load_queue.sv
hdl/cache_port_arbiter.sv
hdl/lsu_top.sv
test/tb_clock.sv
test/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the load-store unit testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module lsu_tb -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/lsu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// ==== test/lsu_tb.sv ====
// Testbench for the load-store unit. Random loads and stores in a 32-word
// window run against a cache-port model and a reference memory, then a
// full store queue is checked for back-pressure. Run with lsu_tb as top.
`timescale 1ns/1ps

module lsu_tb
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
;
    localparam int SQ_DEPTH    = 8;
    localparam int LQ_DEPTH    = 8;
    localparam int N_RANDOM    = 600;
    localparam int CYCLE_LIMIT = 40 * (N_RANDOM + SQ_DEPTH + 1) + 5;

    logic clk, rst, flush, store_commit, ready, took;
    issue_req_t issue;
    load_result_t result;
    mem_req_t mem_req;
    mem_resp_t mem_resp, resp_next;

    logic [63:0] rng = 64'd49544;
    logic [63:0] cache_mem [32];     // what the cache port holds
    logic [63:0] commit_mem [32];    // committed stores only
    logic [63:0] ref_mem [32];       // all stores in program order
    logic        pending [256];
    logic        misal [256];
    logic [63:0] exp_data [256];
    logic [5:0]  exp_cause [256];
    logic [7:0]  exp_strb [256];     // byte lanes of the read
    int          ld_word [256];
    int          load_order [256];
    int          issue_cycle [256];
    int          q_order[$], q_word[$];
    logic [7:0]  q_strb[$];
    logic [63:0] q_data[$];
    int          cycles = 0, order = 0, pending_cnt = 0, idle_run = 0;
    logic [7:0]  next_id = 8'd0;

    tb_clock i_clock (.clk(clk));

    lsu_top #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) i_dut (
        .clk(clk), .rst(rst), .flush(flush), .store_commit(store_commit),
        .issue(issue), .ready(ready), .result(result),
        .mem_req(mem_req), .mem_resp(mem_resp)
    );

    function automatic logic [63:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [7:0] strb,
                                                logic [63:0] data);
        logic [63:0] v;
        v = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) v[b*8 +: 8] = data[b*8 +: 8];
        end
        return v;
    endfunction

    // bytes above the access size become sign or zero fill
    function automatic logic [63:0] sized_value(logic [63:0] raw, int nb, logic uns);
        logic [63:0] v;
        logic fill;
        v = raw;
        fill = !uns && raw[nb*8-1];
        for (int b = nb; b < 8; b++) v[b*8 +: 8] = {8{fill}};
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped");
        end
    endtask

    function automatic logic commit_allowed();
        if (q_order.size() == 0) return 1'b0;
        for (int i = 0; i < 256; i++) begin
            if (pending[i] && load_order[i] < q_order[0]) return 1'b0;  // younger store
        end
        return 1'b1;
    endfunction

    task automatic accept_issue();
        int nb, off, w;
        logic [7:0] strb;
        logic [63:0] data;
        nb = 1 << int'(issue.size);
        off = int'(issue.addr[2:0]);
        w = int'(issue.addr[7:3]);
        order++;
        strb = '0;
        data = '0;
        for (int b = 0; b < nb; b++) begin
            if (off + b < 8) begin
                strb[off+b] = 1'b1;
                data[(off+b)*8 +: 8] = issue.wdata[b*8 +: 8];
            end
        end
        if (issue.op == OP_STORE) begin
            ref_mem[w] = merge_bytes(ref_mem[w], strb, data);
            q_order.push_back(order);
            q_word.push_back(w);
            q_strb.push_back(strb);
            q_data.push_back(data);
        end else begin
            pending[issue.id] = 1'b1;
            pending_cnt++;
            load_order[issue.id] = order;
            issue_cycle[issue.id] = cycles;
            ld_word[issue.id] = w;
            exp_strb[issue.id] = strb;
            misal[issue.id] = (off % nb) != 0;
            exp_cause[issue.id] = misal[issue.id] ? 6'd4 : 6'd0;
            exp_data[issue.id] = misal[issue.id] ? 64'd0 :
                                 sized_value(ref_mem[w] >> (8*off), nb, issue.is_unsigned);
        end
    endtask

    task automatic check_result();
        logic [7:0] id;
        id = result.id;
        if (!pending[id]) fail_now("result came for a load that is not outstanding");
        check($sformatf("load_%0d_cause", id), 64'(exp_cause[id]), 64'(result.cause));
        check($sformatf("load_%0d_data", id), exp_data[id], result.data);
        if (misal[id]) check("misaligned_latency", 64'd2, 64'(cycles - issue_cycle[id]));
        pending[id] = 1'b0;
        misal[id] = 1'b0;
        pending_cnt--;
    endtask

    task automatic serve_port();
        int w;
        if (mem_req.addr > 32'd255) fail_now("cache request outside the address window");
        w = int'(mem_req.addr[7:3]);
        if (mem_req.write) begin
            cache_mem[w] = merge_bytes(cache_mem[w], mem_req.strb, mem_req.wdata);
        end else begin
            if (misal[mem_req.tag]) fail_now("misaligned load sent a read to the cache");
            if (!pending[mem_req.tag]) fail_now("cache read for a load that is not outstanding");
            check($sformatf("read_%0d_addr", mem_req.tag), 64'(ld_word[mem_req.tag] * 8),
                  64'(mem_req.addr));
            check($sformatf("read_%0d_strb", mem_req.tag), 64'(exp_strb[mem_req.tag]),
                  64'(mem_req.strb));
            resp_next.valid = 1'b1;
            resp_next.tag = mem_req.tag;
            resp_next.rdata = cache_mem[w];
        end
    endtask

    task automatic flush_model();
        q_order.delete();
        q_word.delete();
        q_strb.delete();
        q_data.delete();
        for (int i = 0; i < 32; i++) ref_mem[i] = commit_mem[i];
        for (int i = 0; i < 256; i++) begin
            pending[i] = 1'b0;
            misal[i] = 1'b0;
        end
        pending_cnt = 0;
    endtask

    // samples everything at the edge while inputs change 1 ns later
    always @(posedge clk) begin
        resp_next = '0;
        cycles++;
        if (cycles > CYCLE_LIMIT) fail_now("timeout, the run took too many cycles");
        took = !rst && issue.valid && ready;
        if (!rst) begin
            idle_run = mem_req.valid ? 0 : idle_run + 1;
            if (result.valid) check_result();
            if (mem_req.valid) serve_port();
            if (store_commit && q_order.size() > 0) begin
                commit_mem[q_word[0]] = merge_bytes(commit_mem[q_word[0]], q_strb[0], q_data[0]);
                void'(q_order.pop_front());
                void'(q_word.pop_front());
                void'(q_strb.pop_front());
                void'(q_data.pop_front());
            end
            if (flush) flush_model();
            if (took) accept_issue();
        end
    end

    always @(posedge clk) begin
        #1;
        mem_resp = resp_next;   // read data one cycle after the request
    end

    task automatic make_op(input logic only_store);
        logic [63:0] r;
        logic [7:0] a;
        logic [7:0] m;
        r = next_rand();
        issue.valid = 1'b1;
        issue.op = (only_store || r[2:0] < 3'd3) ? OP_STORE : OP_LOAD;
        issue.size = acc_size_t'(r[9:8]);
        issue.is_unsigned = r[10];
        m = 8'((1 << int'(r[9:8])) - 1);
        a = r[23:16];
        if (issue.op == OP_STORE || r[13:11] != 3'd0) a = a & ~m;  // some loads misaligned
        issue.addr = {24'd0, a};
        issue.wdata = next_rand();
        issue.id = next_id;
        next_id = next_id + 8'd1;
    endtask

    task automatic wait_taken();
        do begin
            @(posedge clk);
            #1;
        end while (!took);
        issue.valid = 1'b0;
    endtask

    task automatic random_phase(input int n_ops);
        int sent;
        logic [63:0] r;
        sent = 0;
        while (sent < n_ops) begin
            r = next_rand();
            store_commit = commit_allowed() && r[0];
            if (!issue.valid) begin
                if (r[7:2] == 6'd0) begin
                    flush = 1'b1;
                    store_commit = 1'b0;
                end else if (r[9:8] != 2'd0) begin
                    make_op(1'b0);
                end
            end
            @(posedge clk);
            #1;
            store_commit = 1'b0;
            flush = 1'b0;
            if (took) begin
                sent++;
                issue.valid = 1'b0;
            end
        end
    endtask

    // finish loads, commit and drain every store, compare memories
    task automatic settle();
        while (pending_cnt != 0 || q_order.size() != 0) begin
            store_commit = commit_allowed();   // blocked loads need their store drained
            @(posedge clk);
            #1;
        end
        store_commit = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (idle_run < 4);
        for (int i = 0; i < 32; i++) begin
            check($sformatf("mem_word_%0d", i), commit_mem[i], cache_mem[i]);
        end
    endtask

    task automatic fill_store_queue();
        for (int i = 0; i < SQ_DEPTH; i++) begin
            make_op(1'b1);
            wait_taken();
        end
        check("ready_with_full_sq", 64'd0, 64'(ready));
        make_op(1'b1);
        store_commit = 1'b1;
        @(posedge clk);
        #1;
        store_commit = 1'b0;
        check("store_held_while_full", 64'd0, 64'(took));
        wait_taken();
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            cache_mem[i] = 64'h5a3c_96e1_0f2d_b487 ^ (64'(i) * 64'h0101_0101_0101_0101);
            commit_mem[i] = cache_mem[i];
            ref_mem[i] = cache_mem[i];
        end
        flush_model();
        rst = 1'b1;
        flush = 1'b0;
        store_commit = 1'b0;
        issue = '0;
        mem_resp = '0;
        took = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ready_after_reset", 64'd1, 64'(ready));
        check("result_valid_after_reset", 64'd0, 64'(result.valid));
        check("mem_req_valid_after_reset", 64'd0, 64'(mem_req.valid));
        random_phase(N_RANDOM);
        settle();
        fill_store_queue();
        settle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
// Free-running testbench clock, 4 ns period.
// Instantiated once by the testbench top module.
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;   // half period

endmodule

// ==== hdl/lsu_top.sv ====
// Load-store unit top level. Splits the issue stream into the store and
// load queues and puts both behind one cache port. ready drops while
// either queue is full.
`timescale 1ns/1ps

module lsu_top
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    parameter int LQ_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         store_commit,
    input  issue_req_t   issue,
    output logic         ready,
    output load_result_t result,
    output mem_req_t     mem_req,
    input  mem_resp_t    mem_resp
);
    logic                            take;
    logic                            sq_full;
    logic                            lq_full;
    logic                            drain_done;
    logic                            read_grant;
    issue_req_t                      st_issue;
    issue_req_t                      ld_issue;
    logic [$clog2(SQ_DEPTH):0]       sq_head;
    logic [$clog2(SQ_DEPTH):0]       sq_tail;
    logic [SQ_DEPTH-1:0]             sq_valid;
    logic [SQ_DEPTH-1:0][ADDR_W-1:0] sq_addr;
    logic [SQ_DEPTH-1:0][STRB_W-1:0] sq_strb;
    logic [SQ_DEPTH-1:0][XLEN-1:0]   sq_data;
    mem_req_t                        drain_req;
    mem_req_t                        read_req;
    mem_resp_t                       ld_resp;

    assign ready = !sq_full && !lq_full;
    assign take  = issue.valid && ready;

    always_comb begin
        st_issue       = issue;
        st_issue.valid = take && issue.op == OP_STORE;
        ld_issue       = issue;
        ld_issue.valid = take && issue.op == OP_LOAD;
    end

    store_queue #(.SQ_DEPTH(SQ_DEPTH)) i_store_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .store_commit (store_commit),
        .st_issue     (st_issue),
        .full         (sq_full),
        .sq_head      (sq_head),
        .sq_tail      (sq_tail),
        .sq_valid     (sq_valid),
        .sq_addr      (sq_addr),
        .sq_strb      (sq_strb),
        .sq_data      (sq_data),
        .drain_req    (drain_req),
        .drain_done   (drain_done)
    );

    load_queue #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) i_load_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .ld_issue   (ld_issue),
        .full       (lq_full),
        .sq_head    (sq_head),
        .sq_tail    (sq_tail),
        .sq_valid   (sq_valid),
        .sq_addr    (sq_addr),
        .sq_strb    (sq_strb),
        .sq_data    (sq_data),
        .read_req   (read_req),
        .read_grant (read_grant),
        .mem_resp   (ld_resp),
        .result     (result)
    );

    cache_port_arbiter i_cache_port_arbiter (
        .clk        (clk),
        .rst        (rst),
        .drain_req  (drain_req),
        .read_req   (read_req),
        .mem_req    (mem_req),
        .drain_done (drain_done),
        .read_grant (read_grant),
        .mem_resp   (mem_resp),
        .ld_resp    (ld_resp)
    );

endmodule

// ==== hdl/cache_port_arbiter.sv ====
// Shares the one data-cache port between store drain and load reads.
// Drain has priority and a write is done in its grant cycle. The read
// response one cycle after a grant goes back to the load queue.
`timescale 1ns/1ps

module cache_port_arbiter
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_req_t  drain_req,
    input  mem_req_t  read_req,
    output mem_req_t  mem_req,
    output logic      drain_done,
    output logic      read_grant,
    input  mem_resp_t mem_resp,
    output mem_resp_t ld_resp
);
    logic            rd_pend;                // read granted last cycle
    logic [ID_W-1:0] rd_tag;

    always_comb begin
        mem_req    = drain_req;
        drain_done = drain_req.valid;
        read_grant = 1'b0;
        if (!drain_req.valid) begin
            mem_req    = read_req;
            read_grant = read_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= read_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (read_grant) begin
            rd_tag <= read_req.tag;
        end
    end

    always_comb begin
        ld_resp       = mem_resp;
        ld_resp.valid = mem_resp.valid && rd_pend && mem_resp.tag == rd_tag;
    end

endmodule

// ==== hdl/load_queue.sv ====
// Load entries from issue to result. Each entry is checked every cycle
// against older stores, takes forwarded data when one store covers it,
// waits while a store overlaps it in part, and otherwise reads the cache.
// Finished entries leave one per cycle. A faulting entry goes first so its
// latency stays fixed, the others leave lowest index first.
`timescale 1ns/1ps

module load_queue
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    parameter int LQ_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  issue_req_t                      ld_issue,
    output logic                            full,
    input  logic [$clog2(SQ_DEPTH):0]       sq_head,
    input  logic [$clog2(SQ_DEPTH):0]       sq_tail,
    input  logic [SQ_DEPTH-1:0]             sq_valid,
    input  logic [SQ_DEPTH-1:0][ADDR_W-1:0] sq_addr,
    input  logic [SQ_DEPTH-1:0][STRB_W-1:0] sq_strb,
    input  logic [SQ_DEPTH-1:0][XLEN-1:0]   sq_data,
    output mem_req_t                        read_req,
    input  logic                            read_grant,
    input  mem_resp_t                       mem_resp,
    output load_result_t                    result
);
    localparam int LW = $clog2(LQ_DEPTH);

    typedef struct packed {
        logic [ID_W-1:0]           id;
        logic [ADDR_W-1:0]         addr;
        acc_size_t                 size;
        logic                      is_unsigned;
        logic [$clog2(SQ_DEPTH):0] mark;      // store tail at issue
        exc_cause_t                cause;
        logic [XLEN-1:0]           data;
    } lq_entry_t;

    logic [LQ_DEPTH-1:0] valid;
    lq_state_t           state [LQ_DEPTH];
    lq_entry_t           ent [LQ_DEPTH];
    fwd_result_t         fwd [LQ_DEPTH];
    logic [LQ_DEPTH-1:0] chk;                 // in check or wait
    logic [LQ_DEPTH-1:0] resp_hit;
    logic [LW-1:0]       alloc_idx;
    logic [LW-1:0]       rd_idx;
    logic [LW-1:0]       res_idx;
    logic                rd_hit;
    logic                res_hit;
    logic                res_exc;             // picked entry carries a fault
    logic                take;

    assign full = &valid;
    assign take = ld_issue.valid && !full;

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_fwd
        store_forward #(.SQ_DEPTH(SQ_DEPTH)) i_fwd (
            .ld_addr  (ent[i].addr),
            .ld_strb  (size_strb(ent[i].size, ent[i].addr[2:0])),
            .ld_mark  (ent[i].mark),
            .sq_head  (sq_head),
            .sq_valid (sq_valid),
            .sq_addr  (sq_addr),
            .sq_strb  (sq_strb),
            .sq_data  (sq_data),
            .fwd      (fwd[i])
        );
    end

    // loop runs downward so the lowest index wins each pick
    always_comb begin
        alloc_idx = '0;
        rd_idx    = '0;
        res_idx   = '0;
        rd_hit    = 1'b0;
        res_hit   = 1'b0;
        res_exc   = 1'b0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            chk[i]      = valid[i] && (state[i] == LQ_CHECK || state[i] == LQ_WAIT);
            resp_hit[i] = valid[i] && state[i] == LQ_PENDING && mem_resp.valid &&
                          mem_resp.tag == ent[i].id;
            if (!valid[i]) begin
                alloc_idx = LW'(i);
            end
            if (valid[i] && state[i] == LQ_ACCESS) begin
                rd_hit = 1'b1;
                rd_idx = LW'(i);
            end
            if (valid[i] && state[i] == LQ_DONE &&
                (ent[i].cause != EXC_NONE || !res_exc)) begin   // faults leave first
                res_hit = 1'b1;
                res_idx = LW'(i);
                res_exc = ent[i].cause != EXC_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
            for (int i = 0; i < LQ_DEPTH; i++) begin
                state[i] <= LQ_CHECK;
            end
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                if (chk[i]) begin
                    if (ent[i].cause != EXC_NONE || fwd[i].covered) begin
                        state[i] <= LQ_DONE;
                    end else if (fwd[i].blocked) begin
                        state[i] <= LQ_WAIT;       // recheck next cycle
                    end else begin
                        state[i] <= LQ_ACCESS;
                    end
                end else if (valid[i] && state[i] == LQ_ACCESS && read_grant &&
                             rd_idx == LW'(i)) begin
                    state[i] <= LQ_PENDING;
                end else if (resp_hit[i]) begin
                    state[i] <= LQ_DONE;
                end
            end
            if (res_hit) begin
                valid[res_idx] <= 1'b0;
            end
            if (take) begin
                valid[alloc_idx] <= 1'b1;
                state[alloc_idx] <= LQ_CHECK;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (chk[i] && ent[i].cause == EXC_NONE && fwd[i].covered) begin
                ent[i].data <= extend_load(fwd[i].data, ent[i].size, ent[i].is_unsigned);
            end
            if (resp_hit[i]) begin
                ent[i].data <= extend_load(mem_resp.rdata >> {ent[i].addr[2:0], 3'b000},
                                           ent[i].size, ent[i].is_unsigned);
            end
        end
        if (take) begin
            ent[alloc_idx].id          <= ld_issue.id;
            ent[alloc_idx].addr        <= ld_issue.addr;
            ent[alloc_idx].size        <= ld_issue.size;
            ent[alloc_idx].is_unsigned <= ld_issue.is_unsigned;
            ent[alloc_idx].mark        <= sq_tail;
            ent[alloc_idx].data        <= '0;  // stays zero on a fault
            ent[alloc_idx].cause       <= misaligned(ld_issue.size, ld_issue.addr[2:0]) ?
                                          EXC_LD_MISALIGN : EXC_NONE;
        end
    end

    always_comb begin
        read_req       = '0;
        read_req.valid = rd_hit;
        read_req.addr  = {ent[rd_idx].addr[ADDR_W-1:3], 3'b000};
        read_req.strb  = size_strb(ent[rd_idx].size, ent[rd_idx].addr[2:0]);
        read_req.tag   = ent[rd_idx].id;
    end

    always_comb begin
        result.valid = res_hit;
        result.id    = ent[res_idx].id;
        result.cause = ent[res_idx].cause;
        result.data  = ent[res_idx].data;
    end

endmodule

// ==== hdl/store_forward.sv ====
// Checks one load against the stores that are older than it. The load's
// mark is the store tail at its issue, so entries from head up to the
// mark are older. Result is covered, blocked or neither.
`timescale 1ns/1ps

module store_forward
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int SQ_DEPTH = 8
) (
    input  logic [ADDR_W-1:0]               ld_addr,
    input  logic [STRB_W-1:0]               ld_strb,
    input  logic [$clog2(SQ_DEPTH):0]       ld_mark,
    input  logic [$clog2(SQ_DEPTH):0]       sq_head,
    input  logic [SQ_DEPTH-1:0]             sq_valid,
    input  logic [SQ_DEPTH-1:0][ADDR_W-1:0] sq_addr,
    input  logic [SQ_DEPTH-1:0][STRB_W-1:0] sq_strb,
    input  logic [SQ_DEPTH-1:0][XLEN-1:0]   sq_data,
    output fwd_result_t                     fwd
);
    localparam int PW = $clog2(SQ_DEPTH);

    logic [PW:0]       span;                 // number of older stores
    logic              span_ok;
    logic [PW-1:0]     idx;
    logic [PW-1:0]     hit_idx;
    logic              hit;
    logic [STRB_W-1:0] hit_strb;

    assign span = ld_mark - sq_head;
    // head ran past the mark, nothing older is left
    assign span_ok = span <= (PW + 1)'(SQ_DEPTH);

    // later matches overwrite earlier ones, so the youngest wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int j = 0; j < SQ_DEPTH; j++) begin
            idx = sq_head[PW-1:0] + PW'(j);
            if (span_ok && (PW + 1)'(j) < span && sq_valid[idx] &&
                sq_addr[idx][ADDR_W-1:3] == ld_addr[ADDR_W-1:3] &&
                |(sq_strb[idx] & ld_strb)) begin
                hit     = 1'b1;
                hit_idx = idx;
            end
        end
    end

    assign hit_strb = sq_strb[hit_idx];

    always_comb begin
        fwd.covered = hit && ((hit_strb & ld_strb) == ld_strb);
        fwd.blocked = hit && !fwd.covered;
        fwd.data    = sq_data[hit_idx] >> {ld_addr[2:0], 3'b000};
    end

endmodule

// ==== hdl/store_queue.sv ====
// In-order store buffer. Stores wait here until the core commits them,
// then drain one per grant to the cache port. Entries between head and
// tail are visible to younger loads for forwarding. Flush drops every
// store that is not committed yet.
`timescale 1ns/1ps

module store_queue
    import lsu_cfg_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int SQ_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            store_commit,
    input  issue_req_t                      st_issue,
    output logic                            full,
    output logic [$clog2(SQ_DEPTH):0]       sq_head,
    output logic [$clog2(SQ_DEPTH):0]       sq_tail,
    output logic [SQ_DEPTH-1:0]             sq_valid,
    output logic [SQ_DEPTH-1:0][ADDR_W-1:0] sq_addr,
    output logic [SQ_DEPTH-1:0][STRB_W-1:0] sq_strb,
    output logic [SQ_DEPTH-1:0][XLEN-1:0]   sq_data,
    output mem_req_t                        drain_req,
    input  logic                            drain_done
);
    localparam int PW = $clog2(SQ_DEPTH);

    logic [PW:0]   head;                     // oldest entry
    logic [PW:0]   cmt;                      // first uncommitted entry
    logic [PW:0]   tail;
    logic [PW:0]   cmt_next;
    logic [PW:0]   count;
    logic [PW-1:0] rel;
    logic [PW-1:0] wr_idx;
    logic [PW-1:0] hd_idx;

    assign count   = tail - head;
    assign full    = count == (PW + 1)'(SQ_DEPTH);
    assign wr_idx  = tail[PW-1:0];
    assign hd_idx  = head[PW-1:0];
    assign sq_head = head;
    assign sq_tail = tail;

    // commit never passes the tail
    assign cmt_next = (store_commit && cmt != tail) ? cmt + 1'b1 : cmt;

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            rel         = PW'(i) - hd_idx;
            sq_valid[i] = {1'b0, rel} < count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            cmt  <= '0;
            tail <= '0;
        end else begin
            if (drain_done) begin
                head <= head + 1'b1;
            end
            cmt <= cmt_next;
            if (flush) begin
                tail <= cmt_next;            // drop uncommitted stores
            end else if (st_issue.valid && !full) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_issue.valid && !full && !flush) begin
            sq_addr[wr_idx] <= st_issue.addr;
            sq_strb[wr_idx] <= size_strb(st_issue.size, st_issue.addr[2:0]);
            sq_data[wr_idx] <= st_issue.wdata << {st_issue.addr[2:0], 3'b000};
        end
    end

    // head is offered once committed
    always_comb begin
        drain_req       = '0;
        drain_req.valid = head != cmt;
        drain_req.write = 1'b1;
        drain_req.addr  = {sq_addr[hd_idx][ADDR_W-1:3], 3'b000};
        drain_req.strb  = sq_strb[hd_idx];
        drain_req.wdata = sq_data[hd_idx];
    end

endmodule

// ==== hdl/lsu_bus_pkg.sv ====
// Bundles exchanged between the load-store unit blocks and with the
// core and the data-cache port.
package lsu_bus_pkg;

    import lsu_cfg_pkg::*;

    typedef struct packed {
        logic              valid;
        mem_op_t           op;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        acc_size_t         size;
        logic              is_unsigned;
        logic [XLEN-1:0]   wdata;       // store data, low bytes
    } issue_req_t;

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;        // 8-byte aligned
        logic [STRB_W-1:0] strb;
        logic [XLEN-1:0]   wdata;       // already placed on its byte lanes
        logic [ID_W-1:0]   tag;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] tag;
        logic [XLEN-1:0] rdata;         // whole aligned word
    } mem_resp_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
        exc_cause_t      cause;
        logic [XLEN-1:0] data;
    } load_result_t;

    typedef struct packed {
        logic            covered;       // one older store supplies all bytes
        logic            blocked;       // partial overlap, load must wait
        logic [XLEN-1:0] data;
    } fwd_result_t;

endpackage

// ==== hdl/lsu_cfg_pkg.sv ====
// Widths, encodings and helper functions of the load-store unit.
// Imported by every block that works on access sizes, strobes or causes.
package lsu_cfg_pkg;

    localparam int XLEN   = 64;
    localparam int ADDR_W = 32;
    localparam int ID_W   = 8;
    localparam int STRB_W = 8;

    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD, SZ_DOUBLE} acc_size_t;
    typedef enum logic {OP_LOAD, OP_STORE} mem_op_t;
    typedef enum logic [5:0] {EXC_NONE = 6'd0, EXC_LD_MISALIGN = 6'd4} exc_cause_t;
    typedef enum logic [2:0] {LQ_CHECK, LQ_WAIT, LQ_ACCESS, LQ_PENDING, LQ_DONE} lq_state_t;

    // byte lanes touched by an access inside its 8-byte word
    function automatic logic [STRB_W-1:0] size_strb(acc_size_t size, logic [2:0] off);
        logic [STRB_W-1:0] base;
        case (size)
            SZ_BYTE: base = 8'h01;
            SZ_HALF: base = 8'h03;
            SZ_WORD: base = 8'h0f;
            default: base = 8'hff;
        endcase
        return base << off;
    endfunction

    function automatic logic misaligned(acc_size_t size, logic [2:0] off);
        case (size)
            SZ_HALF:   return off[0];
            SZ_WORD:   return |off[1:0];
            SZ_DOUBLE: return |off;
            default:   return 1'b0;
        endcase
    endfunction

    // raw is already shifted down to the access offset
    function automatic logic [XLEN-1:0] extend_load(logic [XLEN-1:0] raw, acc_size_t size,
                                                    logic is_unsigned);
        case (size)
            SZ_BYTE: return is_unsigned ? {56'd0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
            SZ_HALF: return is_unsigned ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            SZ_WORD: return is_unsigned ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

endpackage
